// File: common/decode_pkg.sv
// Shared definitions for the RV32I decode stage.
// Word and selector types, opcode and funct codes, control and hazard structs.
package decode_pkg;

    // ############################
    // Widths and base types
    // ############################
    localparam int XLEN       = 32;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [ILEN-1:0]       inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [4:0] exe_fun_t;
    typedef logic [3:0] op1_sel_t;
    typedef logic [3:0] op2_sel_t;
    typedef logic [3:0] mem_fun_t;
    typedef logic [3:0] wb_sel_t;

    // ############################
    // Instruction encodings
    // ############################
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // ALU funct3, shared by the register and immediate forms.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // SUB and SRA/SRAI.

    // ############################
    // Selector codes
    // ############################
    localparam exe_fun_t ALU_ADD  = 5'd1;
    localparam exe_fun_t ALU_SUB  = 5'd2;
    localparam exe_fun_t ALU_AND  = 5'd3;
    localparam exe_fun_t ALU_OR   = 5'd4;
    localparam exe_fun_t ALU_XOR  = 5'd5;
    localparam exe_fun_t ALU_SLL  = 5'd6;
    localparam exe_fun_t ALU_SRL  = 5'd7;
    localparam exe_fun_t ALU_SRA  = 5'd8;
    localparam exe_fun_t ALU_SLT  = 5'd9;
    localparam exe_fun_t ALU_SLTU = 5'd10;
    localparam exe_fun_t ALU_JALR = 5'd11;
    localparam exe_fun_t BR_BEQ   = 5'd12;
    localparam exe_fun_t BR_BNE   = 5'd13;
    localparam exe_fun_t BR_BLT   = 5'd14;
    localparam exe_fun_t BR_BGE   = 5'd15;
    localparam exe_fun_t BR_BLTU  = 5'd16;
    localparam exe_fun_t BR_BGEU  = 5'd17;

    localparam op1_sel_t OP1_X   = 4'd0;
    localparam op1_sel_t OP1_RS1 = 4'd1;
    localparam op1_sel_t OP1_PC  = 4'd2;

    localparam op2_sel_t OP2_X   = 4'd0;
    localparam op2_sel_t OP2_RS2 = 4'd1;
    localparam op2_sel_t OP2_IMI = 4'd2;
    localparam op2_sel_t OP2_IMS = 4'd3;
    localparam op2_sel_t OP2_IMJ = 4'd4;
    localparam op2_sel_t OP2_IMU = 4'd5;

    localparam mem_fun_t MEN_X   = 4'd0;
    localparam mem_fun_t MEN_LB  = 4'd1;
    localparam mem_fun_t MEN_LBU = 4'd2;
    localparam mem_fun_t MEN_LH  = 4'd3;
    localparam mem_fun_t MEN_LHU = 4'd4;
    localparam mem_fun_t MEN_LW  = 4'd5;
    localparam mem_fun_t MEN_SB  = 4'd6;
    localparam mem_fun_t MEN_SH  = 4'd7;
    localparam mem_fun_t MEN_SW  = 4'd8;

    localparam wb_sel_t WB_X      = 4'd0;
    localparam wb_sel_t WB_ALU    = 4'd1;
    localparam wb_sel_t WB_PC     = 4'd2;
    localparam wb_sel_t WB_MEMB   = 4'd3;
    localparam wb_sel_t WB_MEMBU  = 4'd4;
    localparam wb_sel_t WB_MEMH   = 4'd5;
    localparam wb_sel_t WB_MEMHU  = 4'd6;
    localparam wb_sel_t WB_MEMW   = 4'd7;

    // ############################
    // Structs
    // ############################
    typedef struct packed {
        exe_fun_t exe_fun;
        op1_sel_t op1_sel;
        op2_sel_t op2_sel;
        mem_fun_t mem_fun;
        logic     rf_wen;
        wb_sel_t  wb_sel;
        logic     jmp_flg;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        logic      rf_wen;
        reg_addr_t wb_addr;
    } hz_src_t;

    typedef struct packed {
        word_t     pc;
        inst_t     inst;
        word_t     op1_data;
        word_t     op2_data;
        word_t     rs2_data;
        reg_addr_t wb_addr;
        word_t     imm_b_sext;
        ctrl_t     ctrl;
    } id_exe_t;

endpackage

// File: rtl/reg_file.sv
// Integer register file with two read ports and one write port.
// x0 reads as zero and ignores writes.
`timescale 1ns/1ps

module reg_file
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data
);

    word_t regs [1:NUM_REGS-1];   // No storage for x0.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Reads see the array before the edge, so there is no write bypass.
    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        if (rs1_addr != '0) begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr != '0) begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

// File: decode/inst_decoder.sv
// Instruction decode table for the kept RV32I subset.
// Maps an instruction word to its control bundle.
`timescale 1ns/1ps

module inst_decoder
    import decode_pkg::*;
(
    input  inst_t inst,
    output ctrl_t ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    function automatic ctrl_t mk(input exe_fun_t fun, input op1_sel_t s1,
                                 input op2_sel_t s2, input mem_fun_t mem,
                                 input logic wen, input wb_sel_t wb);
        ctrl_t c;
        c.exe_fun = fun;
        c.op1_sel = s1;
        c.op2_sel = s2;
        c.mem_fun = mem;
        c.rf_wen  = wen;
        c.wb_sel  = wb;
        c.jmp_flg = 1'b0;
        return c;
    endfunction

    function automatic ctrl_t alu_rr(input exe_fun_t fun);
        return mk(fun, OP1_RS1, OP2_RS2, MEN_X, 1'b1, WB_ALU);
    endfunction

    function automatic ctrl_t alu_ri(input exe_fun_t fun);
        return mk(fun, OP1_RS1, OP2_IMI, MEN_X, 1'b1, WB_ALU);
    endfunction

    function automatic ctrl_t branch(input exe_fun_t fun);
        return mk(fun, OP1_RS1, OP2_RS2, MEN_X, 1'b0, WB_X);
    endfunction

    always_comb begin
        ctrl = mk(ALU_ADD, OP1_X, OP2_X, MEN_X, 1'b0, WB_X);   // No-op unless matched.
        case (opcode)
            OPC_LOAD: begin
                case (funct3)
                    F3_LB:   ctrl = mk(ALU_ADD, OP1_RS1, OP2_IMI, MEN_LB, 1'b1, WB_MEMB);
                    F3_LBU:  ctrl = mk(ALU_ADD, OP1_RS1, OP2_IMI, MEN_LBU, 1'b1, WB_MEMBU);
                    F3_LH:   ctrl = mk(ALU_ADD, OP1_RS1, OP2_IMI, MEN_LH, 1'b1, WB_MEMH);
                    F3_LHU:  ctrl = mk(ALU_ADD, OP1_RS1, OP2_IMI, MEN_LHU, 1'b1, WB_MEMHU);
                    F3_LW:   ctrl = mk(ALU_ADD, OP1_RS1, OP2_IMI, MEN_LW, 1'b1, WB_MEMW);
                    default: ;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    F3_SB:   ctrl = mk(ALU_ADD, OP1_RS1, OP2_IMS, MEN_SB, 1'b0, WB_X);
                    F3_SH:   ctrl = mk(ALU_ADD, OP1_RS1, OP2_IMS, MEN_SH, 1'b0, WB_X);
                    F3_SW:   ctrl = mk(ALU_ADD, OP1_RS1, OP2_IMS, MEN_SW, 1'b0, WB_X);
                    default: ;
                endcase
            end
            OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD_SUB: ctrl = alu_rr(ALU_ADD);
                        F3_SLL:     ctrl = alu_rr(ALU_SLL);
                        F3_SLT:     ctrl = alu_rr(ALU_SLT);
                        F3_SLTU:    ctrl = alu_rr(ALU_SLTU);
                        F3_XOR:     ctrl = alu_rr(ALU_XOR);
                        F3_SRL_SRA: ctrl = alu_rr(ALU_SRL);
                        F3_OR:      ctrl = alu_rr(ALU_OR);
                        F3_AND:     ctrl = alu_rr(ALU_AND);
                        default:    ;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    if (funct3 == F3_ADD_SUB) begin
                        ctrl = alu_rr(ALU_SUB);
                    end else if (funct3 == F3_SRL_SRA) begin
                        ctrl = alu_rr(ALU_SRA);
                    end
                end
            end
            OPC_OP_IMM: begin
                case (funct3)
                    F3_ADD_SUB: ctrl = alu_ri(ALU_ADD);
                    F3_SLT:     ctrl = alu_ri(ALU_SLT);
                    F3_SLTU:    ctrl = alu_ri(ALU_SLTU);
                    F3_XOR:     ctrl = alu_ri(ALU_XOR);
                    F3_OR:      ctrl = alu_ri(ALU_OR);
                    F3_AND:     ctrl = alu_ri(ALU_AND);
                    F3_SLL: begin
                        if (funct7 == F7_BASE) ctrl = alu_ri(ALU_SLL);
                    end
                    F3_SRL_SRA: begin
                        if (funct7 == F7_BASE) ctrl = alu_ri(ALU_SRL);
                        else if (funct7 == F7_ALT) ctrl = alu_ri(ALU_SRA);
                    end
                    default:    ;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  ctrl = branch(BR_BEQ);
                    F3_BNE:  ctrl = branch(BR_BNE);
                    F3_BLT:  ctrl = branch(BR_BLT);
                    F3_BGE:  ctrl = branch(BR_BGE);
                    F3_BLTU: ctrl = branch(BR_BLTU);
                    F3_BGEU: ctrl = branch(BR_BGEU);
                    default: ;
                endcase
            end
            OPC_JAL: begin
                ctrl = mk(ALU_ADD, OP1_PC, OP2_IMJ, MEN_X, 1'b1, WB_PC);
                ctrl.jmp_flg = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == F3_JALR) begin
                    ctrl = mk(ALU_JALR, OP1_RS1, OP2_IMI, MEN_X, 1'b1, WB_PC);
                    ctrl.jmp_flg = 1'b1;
                end
            end
            OPC_LUI:   ctrl = mk(ALU_ADD, OP1_X, OP2_IMU, MEN_X, 1'b1, WB_ALU);
            OPC_AUIPC: ctrl = mk(ALU_ADD, OP1_PC, OP2_IMU, MEN_X, 1'b1, WB_ALU);
            default:   ;
        endcase
    end

endmodule

// File: decode/operand_sel.sv
// Immediate extraction and operand selection.
// Builds the I, S, B, J and U immediates and drives op1/op2.
`timescale 1ns/1ps

module operand_sel
    import decode_pkg::*;
(
    input  word_t pc,
    input  inst_t inst,
    input  ctrl_t ctrl,
    input  word_t rs1_data,
    input  word_t rs2_data,
    output word_t op1_data,
    output word_t op2_data,
    output word_t imm_b_sext
);

    logic [11:0] imm_i;
    logic [11:0] imm_s;
    logic [11:0] imm_b;
    logic [19:0] imm_j;
    logic [19:0] imm_u;

    word_t imm_i_sext;
    word_t imm_s_sext;
    word_t imm_j_sext;
    word_t imm_u_shifted;

    // ##############################
    // Immediates
    // ##############################
    assign imm_i = inst[31:20];
    assign imm_s = {inst[31:25], inst[11:7]};
    assign imm_b = {inst[31], inst[7], inst[30:25], inst[11:8]};
    assign imm_j = {inst[31], inst[19:12], inst[20], inst[30:21]};
    assign imm_u = inst[31:12];

    assign imm_i_sext    = {{20{imm_i[11]}}, imm_i};
    assign imm_s_sext    = {{20{imm_s[11]}}, imm_s};
    assign imm_b_sext    = {{19{imm_b[11]}}, imm_b, 1'b0};   // Branch offsets are halfword aligned.
    assign imm_j_sext    = {{11{imm_j[19]}}, imm_j, 1'b0};
    assign imm_u_shifted = {imm_u, 12'b0};

    // ##############################
    // Operand muxes
    // ##############################
    always_comb begin
        case (ctrl.op1_sel)
            OP1_RS1: op1_data = rs1_data;
            OP1_PC:  op1_data = pc;
            default: op1_data = '0;   // LUI relies on a zero op1.
        endcase
    end

    always_comb begin
        case (ctrl.op2_sel)
            OP2_RS2: op2_data = rs2_data;
            OP2_IMI: op2_data = imm_i_sext;
            OP2_IMS: op2_data = imm_s_sext;
            OP2_IMJ: op2_data = imm_j_sext;
            OP2_IMU: op2_data = imm_u_shifted;
            default: op2_data = '0;
        endcase
    end

endmodule

// File: decode/hazard_unit.sv
// Read-after-write hazard detection against execute, memory and writeback.
`timescale 1ns/1ps

module hazard_unit
    import decode_pkg::*;
(
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  hz_src_t   hz_exe,
    input  hz_src_t   hz_mem,
    input  hz_src_t   hz_wb,
    output logic      stall_flg
);

    // A pending write only matters for a source register other than x0.
    function automatic logic src_hit(input hz_src_t src, input reg_addr_t addr);
        return src.valid && src.rf_wen && (addr != '0) && (src.wb_addr == addr);
    endfunction

    logic exe_hit;
    logic mem_hit;
    logic wb_hit;

    assign exe_hit = src_hit(hz_exe, rs1_addr) || src_hit(hz_exe, rs2_addr);
    assign mem_hit = src_hit(hz_mem, rs1_addr) || src_hit(hz_mem, rs2_addr);
    assign wb_hit  = src_hit(hz_wb, rs1_addr) || src_hit(hz_wb, rs2_addr);

    assign stall_flg = exe_hit || mem_hit || wb_hit;

endmodule

// File: decode/decode_stage.sv
// Decode stage top level.
// Register file, decode table, operand select, hazard check and ID/EX register.
`timescale 1ns/1ps

module decode_stage
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      id_valid,
    input  word_t     id_pc,
    input  inst_t     id_inst,
    output logic      stall_flg,
    input  hz_src_t   hz_exe,
    input  hz_src_t   hz_mem,
    input  hz_src_t   hz_wb,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output logic      id_exe_valid,
    output id_exe_t   id_exe
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     op1_data;
    word_t     op2_data;
    word_t     imm_b_sext;
    ctrl_t     ctrl;
    id_exe_t   id_exe_d;

    assign rs1_addr = id_inst[19:15];
    assign rs2_addr = id_inst[24:20];
    assign rd_addr  = id_inst[11:7];

    reg_file i_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    inst_decoder i_inst_decoder (
        .inst (id_inst),
        .ctrl (ctrl)
    );

    operand_sel i_operand_sel (
        .pc         (id_pc),
        .inst       (id_inst),
        .ctrl       (ctrl),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .op1_data   (op1_data),
        .op2_data   (op2_data),
        .imm_b_sext (imm_b_sext)
    );

    hazard_unit i_hazard_unit (
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .hz_exe    (hz_exe),
        .hz_mem    (hz_mem),
        .hz_wb     (hz_wb),
        .stall_flg (stall_flg)
    );

    // ##############################
    // ID/EX register
    // ##############################
    assign id_exe_d = '{
        pc:         id_pc,
        inst:       id_inst,
        op1_data:   op1_data,
        op2_data:   op2_data,
        rs2_data:   rs2_data,   // Store data travels even when op2 is an immediate.
        wb_addr:    rd_addr,
        imm_b_sext: imm_b_sext,
        ctrl:       ctrl
    };

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_exe_valid <= 1'b0;
        end else begin
            id_exe_valid <= id_valid && !stall_flg;   // A stall sends a bubble.
        end
    end

    always_ff @(posedge clk) begin
        id_exe <= id_exe_d;
    end

endmodule

// File: verif/decode_stage_asserts.sv
// Concurrent assertions on the decode stage valid and stall behavior.
// Bound into decode_stage from the testbench.
`timescale 1ns/1ps

module decode_stage_asserts (
    input logic clk,
    input logic rst_n,
    input logic stall_flg,
    input logic id_exe_valid
);

    int fail_count = 0;

    // The first edge out of reset still shows the reset value.
    a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !id_exe_valid)
        else begin
            fail_count++;
            $error("id_exe_valid was high on the cycle after reset release");
        end

    // A stalled edge always loads a bubble.
    a_bubble_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n) stall_flg |=> !id_exe_valid)
        else begin
            fail_count++;
            $error("id_exe_valid was high after an edge with stall_flg set");
        end

endmodule

// File: verif/tb_decode_stage.sv
// Testbench for the decode stage.
// Random stimulus, reference decode model, compare tasks and a watchdog.
`timescale 1ns/1ps

module tb_decode_stage
    import decode_pkg::*;
;

    localparam int CLK_PERIOD   = 4;
    localparam int N_RAND       = 40;   // Instructions per random group.
    localparam int N_HZ         = 9;
    localparam int HOLD         = 3;    // Stall cycles per hazard case.
    localparam int TOTAL_ISSUED = 4 * N_RAND + 2 * N_HZ + (NUM_REGS - 1) + 4;
    localparam int STALL_CYCLES = N_HZ * HOLD;

    localparam exe_fun_t ALU_BY_F3 [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                           ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    localparam exe_fun_t BR_BY_F3 [8] = '{BR_BEQ, BR_BNE, ALU_ADD, ALU_ADD,
                                          BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
    localparam mem_fun_t LOAD_MEM [8] = '{MEN_LB, MEN_LH, MEN_LW, MEN_X,
                                          MEN_LBU, MEN_LHU, MEN_X, MEN_X};
    localparam wb_sel_t LOAD_WB [8] = '{WB_MEMB, WB_MEMH, WB_MEMW, WB_X,
                                        WB_MEMBU, WB_MEMHU, WB_X, WB_X};
    localparam mem_fun_t STORE_MEM [8] = '{MEN_SB, MEN_SH, MEN_SW, MEN_X,
                                           MEN_X, MEN_X, MEN_X, MEN_X};
    localparam logic [6:0] FLOW_OPC [5] = '{OPC_BRANCH, OPC_JAL, OPC_JALR,
                                            OPC_LUI, OPC_AUIPC};

    logic      clk = 1'b0;
    logic      rst_n;
    logic      id_valid;
    word_t     id_pc;
    inst_t     id_inst;
    logic      stall_flg;
    hz_src_t   hz_exe;
    hz_src_t   hz_mem;
    hz_src_t   hz_wb;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      id_exe_valid;
    id_exe_t   id_exe;

    word_t   rf_model [NUM_REGS];
    id_exe_t exp_payload;
    logic    exp_valid = 1'b0;
    logic    exp_stall;
    logic    exp_known = 1'b0;
    int      checks = 0;
    int      errors = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    decode_stage i_dut (.*);

    bind decode_stage decode_stage_asserts i_asserts (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_flg    (stall_flg),
        .id_exe_valid (id_exe_valid)
    );

    // ##############################
    // Reference model
    // ##############################
    function automatic ctrl_t make_ctrl(input exe_fun_t fun, input op1_sel_t s1,
                                        input op2_sel_t s2, input mem_fun_t mem,
                                        input wb_sel_t wb, input logic jmp);
        return '{exe_fun: fun, op1_sel: s1, op2_sel: s2, mem_fun: mem,
                 rf_wen: (wb != WB_X), wb_sel: wb, jmp_flg: jmp};   // Only writebacks enable rd.
    endfunction

    function automatic id_exe_t ref_decode(input inst_t inst, input word_t pc,
                                           input word_t rf [NUM_REGS]);
        id_exe_t    e;
        ctrl_t      c;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      imm_i;
        f3 = inst[14:12];
        f7 = inst[31:25];
        imm_i = word_t'($signed(inst) >>> 20);
        c = make_ctrl(ALU_ADD, OP1_X, OP2_X, MEN_X, WB_X, 1'b0);
        case (inst[6:0])
            OPC_OP: begin
                if (f7 == F7_BASE) begin
                    c = make_ctrl(ALU_BY_F3[f3], OP1_RS1, OP2_RS2, MEN_X, WB_ALU, 1'b0);
                end else if (f7 == F7_ALT && (f3 == 3'd0 || f3 == 3'd5)) begin
                    c = make_ctrl((f3 == 3'd0) ? ALU_SUB : ALU_SRA, OP1_RS1, OP2_RS2,
                                  MEN_X, WB_ALU, 1'b0);
                end
            end
            OPC_OP_IMM: begin
                if (f3[1:0] != 2'b01 || f7 == F7_BASE) begin
                    c = make_ctrl(ALU_BY_F3[f3], OP1_RS1, OP2_IMI, MEN_X, WB_ALU, 1'b0);
                end else if (f3 == 3'd5 && f7 == F7_ALT) begin
                    c = make_ctrl(ALU_SRA, OP1_RS1, OP2_IMI, MEN_X, WB_ALU, 1'b0);
                end
            end
            OPC_LOAD: begin
                if (LOAD_MEM[f3] != MEN_X) begin
                    c = make_ctrl(ALU_ADD, OP1_RS1, OP2_IMI, LOAD_MEM[f3], LOAD_WB[f3], 1'b0);
                end
            end
            OPC_STORE: begin
                if (STORE_MEM[f3] != MEN_X) begin
                    c = make_ctrl(ALU_ADD, OP1_RS1, OP2_IMS, STORE_MEM[f3], WB_X, 1'b0);
                end
            end
            OPC_BRANCH: begin
                if (f3[2:1] != 2'b01) begin
                    c = make_ctrl(BR_BY_F3[f3], OP1_RS1, OP2_RS2, MEN_X, WB_X, 1'b0);
                end
            end
            OPC_JAL:   c = make_ctrl(ALU_ADD, OP1_PC, OP2_IMJ, MEN_X, WB_PC, 1'b1);
            OPC_JALR: begin
                if (f3 == 3'd0) begin
                    c = make_ctrl(ALU_JALR, OP1_RS1, OP2_IMI, MEN_X, WB_PC, 1'b1);
                end
            end
            OPC_LUI:   c = make_ctrl(ALU_ADD, OP1_X, OP2_IMU, MEN_X, WB_ALU, 1'b0);
            OPC_AUIPC: c = make_ctrl(ALU_ADD, OP1_PC, OP2_IMU, MEN_X, WB_ALU, 1'b0);
            default:   ;
        endcase
        e.ctrl = c;
        e.pc = pc;
        e.inst = inst;
        e.wb_addr = inst[11:7];
        e.rs2_data = rf[inst[24:20]];
        e.imm_b_sext = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        case (c.op1_sel)
            OP1_RS1: e.op1_data = rf[inst[19:15]];
            OP1_PC:  e.op1_data = pc;
            default: e.op1_data = '0;
        endcase
        case (c.op2_sel)
            OP2_RS2: e.op2_data = rf[inst[24:20]];
            OP2_IMI: e.op2_data = imm_i;
            OP2_IMS: e.op2_data = {imm_i[31:5], inst[11:7]};
            OP2_IMJ: e.op2_data = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            OP2_IMU: e.op2_data = {inst[31:12], 12'h000};
            default: e.op2_data = '0;
        endcase
        return e;
    endfunction

    function automatic logic writer_hits(input hz_src_t w, input inst_t inst);
        return w.valid && w.rf_wen && (w.wb_addr != 5'd0) &&
               (w.wb_addr == inst[19:15] || w.wb_addr == inst[24:20]);
    endfunction

    // ##############################
    // Compare tasks
    // ##############################
    task automatic check_valid(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_ctrl(input ctrl_t got, input ctrl_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR id_exe.ctrl: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Inputs are stable at the rising edge, so the expected result is taken there.
    always @(posedge clk) begin
        exp_stall = writer_hits(hz_exe, id_inst) || writer_hits(hz_mem, id_inst) ||
                    writer_hits(hz_wb, id_inst);
        if (rst_n) begin
            check_valid("stall_flg", stall_flg, exp_stall);
        end
        exp_valid = rst_n && id_valid && !exp_stall;
        exp_payload = ref_decode(id_inst, id_pc, rf_model);
        if (rst_n && wb_en && wb_addr != 5'd0) begin
            rf_model[wb_addr] = wb_data;
        end
        exp_known = 1'b1;
    end

    always @(negedge clk) begin
        if (exp_known) begin
            check_valid("id_exe_valid", id_exe_valid, exp_valid);
            if (exp_valid) begin
                check_ctrl(id_exe.ctrl, exp_payload.ctrl);
                check_word("id_exe.pc", id_exe.pc, exp_payload.pc);
                check_word("id_exe.inst", id_exe.inst, exp_payload.inst);
                check_word("id_exe.op1_data", id_exe.op1_data, exp_payload.op1_data);
                check_word("id_exe.op2_data", id_exe.op2_data, exp_payload.op2_data);
                check_word("id_exe.rs2_data", id_exe.rs2_data, exp_payload.rs2_data);
                check_word("id_exe.imm_b_sext", id_exe.imm_b_sext, exp_payload.imm_b_sext);
                check_word("id_exe.wb_addr", word_t'(id_exe.wb_addr),
                           word_t'(exp_payload.wb_addr));
            end
        end
    end

    // ##############################
    // Stimulus
    // ##############################
    function automatic inst_t random_inst(input int group);
        inst_t      i;
        logic [6:0] opc;
        i = $urandom;
        case (group)
            0: begin
                opc = ($urandom % 2 == 0) ? OPC_OP : OPC_OP_IMM;
                if (opc == OPC_OP || i[13:12] == 2'b01) begin
                    i[31:25] = ($urandom % 2 == 0) ? F7_BASE : F7_ALT;
                end
            end
            1: opc = ($urandom % 2 == 0) ? OPC_LOAD : OPC_STORE;
            2: begin
                opc = FLOW_OPC[3'($urandom % 5)];
                if (opc == OPC_JALR) i[14:12] = F3_JALR;
            end
            default: begin
                do begin
                    opc = 7'($urandom);
                end while (opc inside {OPC_LOAD, OPC_STORE, OPC_OP, OPC_OP_IMM, OPC_BRANCH,
                                       OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC});
            end
        endcase
        i[6:0] = opc;
        return i;
    endfunction

    task automatic set_writer(input int stage, input hz_src_t w);
        hz_exe = '0;
        hz_mem = '0;
        hz_wb = '0;
        case (stage)
            0:       hz_exe = w;
            1:       hz_mem = w;
            default: hz_wb = w;
        endcase
    endtask

    task automatic drive_inst(input inst_t inst);
        id_valid = 1'b1;
        id_inst = inst;
        id_pc = {30'($urandom), 2'b00};
        wb_en = 1'b0;
    endtask

    task automatic issue(input inst_t inst);
        @(negedge clk);
        drive_inst(inst);
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        @(negedge clk);
        id_valid = 1'b0;
        wb_en = 1'b1;
        wb_addr = addr;
        wb_data = data;
    endtask

    task automatic idle();
        @(negedge clk);
        id_valid = 1'b0;
        wb_en = 1'b0;
        set_writer(0, '0);
    endtask

    initial begin
        #(CLK_PERIOD * (TOTAL_ISSUED + STALL_CYCLES + 50));
        $display("Timeout: the run did not finish in the expected time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        inst_t     inst;
        hz_src_t   w;
        reg_addr_t ra;
        reg_addr_t rb;
        void'($urandom(96));
        rst_n = 1'b0;
        id_valid = 1'b0;
        id_pc = '0;
        id_inst = '0;
        wb_en = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        set_writer(0, '0);
        foreach (rf_model[i]) rf_model[i] = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        for (int r = 1; r < NUM_REGS; r++) write_reg(reg_addr_t'(r), $urandom);
        for (int g = 0; g < 3; g++) begin
            for (int n = 0; n < N_RAND; n++) issue(random_inst(g));
        end

        // Each case stalls on a matching writer, then runs one that must not stall.
        for (int k = 0; k < N_HZ; k++) begin
            ra = 5'($urandom_range(31, 1));
            rb = 5'($urandom_range(31, 1));
            inst = {F7_BASE, rb, ra, F3_ADD_SUB, 5'($urandom), OPC_OP};
            w = '{valid: 1'b1, rf_wen: 1'b1, wb_addr: (k % 2 == 0) ? ra : rb};
            @(negedge clk);
            set_writer(k % 3, w);
            drive_inst(inst);
            repeat (HOLD) @(negedge clk);
            set_writer(k % 3, '0);
            case (k % 3)
                0: w.valid = 1'b0;
                1: w.rf_wen = 1'b0;
                default: begin
                    w.wb_addr = '0;
                    inst[19:15] = '0;
                end
            endcase
            @(negedge clk);
            set_writer(k % 3, w);
            drive_inst(inst);
        end
        idle();

        write_reg('0, 32'hdead_beef);   // x0 must still read as zero.
        issue({F7_BASE, 5'd0, 5'd0, F3_ADD_SUB, 5'd1, OPC_OP});
        for (int n = 0; n < N_RAND; n++) issue(random_inst(3));

        idle();
        repeat (2) @(negedge clk);
        #1;
        $display("Checks: %0d  errors: %0d  assertion failures: %0d",
                 checks, errors, i_dut.i_asserts.fail_count);
        if (errors == 0 && i_dut.i_asserts.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
common/decode_pkg.sv
rtl/reg_file.sv
decode/inst_decoder.sv
decode/operand_sel.sv
decode/hazard_unit.sv
decode/decode_stage.sv
verif/decode_stage_asserts.sv
verif/tb_decode_stage.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_decode_stage -f sim.f -o sim_decode
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_decode +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1
